//--- cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	parameter int DATA_W      = 8;  // signed fm and weight values
	parameter int ACC_W       = 24;
	parameter int FM_SIZE_MAX = 8;
	parameter int KS_MAX      = 3;
	parameter int DEPTH_MAX   = 4;
	parameter int KNUM_MAX    = 4;

	// fm word at slice*64 + x*8 + y
	parameter int FM_ADDR_W = 8;
	// weight at bank*36 + slice*9 + ky*3 + kx
	parameter int W_ADDR_W  = 7;

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [ACC_W-1:0]  acc_t;
	typedef logic [FM_ADDR_W-1:0]     fm_addr_t;
	typedef logic [W_ADDR_W-1:0]      w_addr_t;
	typedef logic [3:0]               size_t; // sides, depth, kernel count

	typedef enum logic [1:0] {
		LOAD,
		RUN,
		WAIT_W, // kernel start held back by a pending refill
		DONE
	} layer_state_t;

endpackage

`default_nettype wire

//--- fm_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fm_ram #(
	parameter int FM_SIZE_MAX = cnn_pkg::FM_SIZE_MAX,
	parameter int DEPTH_MAX   = cnn_pkg::DEPTH_MAX
) (
	input  wire                    clk,
	input  wire                    we_i,
	input  wire cnn_pkg::fm_addr_t waddr_i,
	input  wire cnn_pkg::data_t    wdata_i,
	input  wire cnn_pkg::fm_addr_t raddr_i,
	output cnn_pkg::data_t         rdata_o
);
	import cnn_pkg::*;

	// one full plane per slice, even for smaller maps
	localparam int WORDS = DEPTH_MAX * FM_SIZE_MAX * FM_SIZE_MAX;

	data_t mem [WORDS];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i; // host load
		end
	end

	// registered read, data one cycle after address
	always_ff @(posedge clk) begin
		rdata_o <= mem[raddr_i];
	end

endmodule

`default_nettype wire

//--- weight_ram.sv
`timescale 1ns/1ps
`default_nettype none

module weight_ram #(
	parameter int KS_MAX    = cnn_pkg::KS_MAX,
	parameter int DEPTH_MAX = cnn_pkg::DEPTH_MAX
) (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   we_i,
	input  wire cnn_pkg::w_addr_t waddr_i,
	input  wire cnn_pkg::data_t   wdata_i,
	input  wire cnn_pkg::w_addr_t raddr_i,
	output cnn_pkg::data_t        rdata_o,
	input  wire                   refill_i,
	input  wire cnn_pkg::w_addr_t refill_base_i
);
	import cnn_pkg::*;

	localparam int BANK = DEPTH_MAX * KS_MAX * KS_MAX; // weights per kernel

	data_t mem [2*BANK];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		rdata_o <= mem[raddr_i];
	end

	// a refill may only touch the freed bank, never the one the engine reads
	a_refill_bank: assert property (@(posedge clk) disable iff (!rst)
		refill_i && we_i |->
			waddr_i >= refill_base_i && waddr_i < refill_base_i + BANK
			&& ((waddr_i >= BANK) != (raddr_i >= BANK)));

endmodule

`default_nettype wire

//--- window_counter.sv
`timescale 1ns/1ps
`default_nettype none

module window_counter #(
	parameter int FM_SIZE_MAX = cnn_pkg::FM_SIZE_MAX,
	parameter int KS_MAX      = cnn_pkg::KS_MAX,
	parameter int DEPTH_MAX   = cnn_pkg::DEPTH_MAX
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 clear_i,
	input  wire                 advance_i,
	input  wire                 bank_i,
	input  wire cnn_pkg::size_t fm_size_i,
	input  wire cnn_pkg::size_t kernel_size_i,
	input  wire cnn_pkg::size_t fm_depth_i,
	input  wire cnn_pkg::size_t kernel_num_i,
	output cnn_pkg::fm_addr_t   fm_raddr_o,
	output cnn_pkg::w_addr_t    w_raddr_o,
	output logic                first_tap_o,
	output logic                last_tap_o,
	output logic                kernel_end_o,
	output logic                layer_end_o
);
	import cnn_pkg::*;

	localparam int FM_PLANE = FM_SIZE_MAX * FM_SIZE_MAX;
	localparam int KS_SQ    = KS_MAX * KS_MAX;
	localparam int W_BANK   = DEPTH_MAX * KS_SQ;

	size_t kernel;
	size_t x;
	size_t y;
	size_t slice;
	size_t ky;
	size_t kx;
	size_t xy_last;
	logic  kx_end;
	logic  ky_end;
	logic  slice_end;
	logic  y_end;
	logic  x_end;
	logic  k_end;
	logic  win_end;

	assign xy_last   = fm_size_i - kernel_size_i; // last valid window origin
	assign kx_end    = (kx == kernel_size_i - 4'd1);
	assign ky_end    = (ky == kernel_size_i - 4'd1);
	assign slice_end = (slice == fm_depth_i - 4'd1);
	assign y_end     = (y == xy_last);
	assign x_end     = (x == xy_last);
	assign k_end     = (kernel == kernel_num_i - 4'd1);
	assign win_end   = kx_end && ky_end && slice_end;

	// kx innermost, then ky, slice, y, x, kernel
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			kernel <= '0;
			x      <= '0;
			y      <= '0;
			slice  <= '0;
			ky     <= '0;
			kx     <= '0;
		end else if (clear_i) begin
			kernel <= '0;
			x      <= '0;
			y      <= '0;
			slice  <= '0;
			ky     <= '0;
			kx     <= '0;
		end else if (advance_i) begin
			kx <= kx_end ? '0 : kx + 4'd1;
			if (kx_end) begin
				ky <= ky_end ? '0 : ky + 4'd1;
			end
			if (kx_end && ky_end) begin
				slice <= slice_end ? '0 : slice + 4'd1;
			end
			if (win_end) begin
				y <= y_end ? '0 : y + 4'd1;
				if (y_end) begin
					x <= x_end ? '0 : x + 4'd1;
					if (x_end) begin
						kernel <= k_end ? '0 : kernel + 4'd1; // wraps at layer end
					end
				end
			end
		end
	end

	assign fm_raddr_o = fm_addr_t'(slice * FM_PLANE + (x + kx) * FM_SIZE_MAX + (y + ky));
	assign w_raddr_o  = w_addr_t'(bank_i * W_BANK + slice * KS_SQ + ky * KS_MAX + kx);

	assign first_tap_o  = advance_i && kx == '0 && ky == '0 && slice == '0;
	assign last_tap_o   = advance_i && win_end;
	assign kernel_end_o = last_tap_o && y_end && x_end;
	assign layer_end_o  = kernel_end_o && k_end;

	a_kernel_fits: assert property (@(posedge clk) disable iff (!rst)
		advance_i |-> kernel_size_i <= fm_size_i);

endmodule

`default_nettype wire

//--- conv_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module conv_fsm #(
	parameter int KS_MAX    = cnn_pkg::KS_MAX,
	parameter int DEPTH_MAX = cnn_pkg::DEPTH_MAX
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire [1:0]           layer_type_i,
	input  wire                 fm_load_done_i,
	input  wire                 w_load_done_i,
	input  wire                 fm_we_i,
	input  wire                 w_we_i,
	input  wire                 kernel_end_i,
	input  wire                 layer_end_i,
	input  wire cnn_pkg::size_t kernel_num_i,
	input  wire                 result_valid_i,
	output logic                advance_o,
	output logic                clear_o,
	output logic                bank_o,
	output logic                init_fm_ram_ready_o,
	output logic                init_weight_ram_ready_o,
	output logic                update_weight_o,
	output cnn_pkg::w_addr_t    update_weight_addr_o,
	output logic                layer_ready_o
);
	import cnn_pkg::*;

	localparam w_addr_t BANK1_BASE = w_addr_t'(DEPTH_MAX * KS_MAX * KS_MAX);

	layer_state_t state;
	layer_state_t state_nxt;
	size_t        kidx;       // index of the running kernel
	logic [1:0]   end_d;      // layer end, aligned to the mac output
	logic         refill_need;

	assign advance_o   = (state == RUN);
	assign clear_o     = (state == LOAD); // counters parked at zero while loading
	assign refill_need = ({1'b0, kidx} + 5'd2) < {1'b0, kernel_num_i};

	always_comb begin
		state_nxt = state;
		case (state)
			LOAD: begin
				if (layer_type_i == 2'd1 && init_fm_ram_ready_o && init_weight_ram_ready_o) begin
					state_nxt = RUN;
				end
			end
			RUN: begin
				if (layer_end_i) begin
					state_nxt = DONE;
				end else if (kernel_end_i) begin
					state_nxt = WAIT_W;
				end
			end
			WAIT_W: begin
				if (!update_weight_o) begin
					state_nxt = RUN;
				end
			end
			DONE: begin
				if (layer_type_i == 2'd0) begin
					state_nxt = LOAD;
				end
			end
			default: state_nxt = LOAD;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= LOAD;
		end else begin
			state <= state_nxt;
		end
	end

	// init ready flags, only tracked while loading
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			init_fm_ram_ready_o     <= 1'b0;
			init_weight_ram_ready_o <= 1'b0;
		end else if (state == LOAD) begin
			if (fm_load_done_i) begin
				init_fm_ram_ready_o <= 1'b1;
			end else if (fm_we_i) begin
				init_fm_ram_ready_o <= 1'b0;
			end
			if (w_load_done_i) begin
				init_weight_ram_ready_o <= 1'b1;
			end else if (w_we_i) begin
				init_weight_ram_ready_o <= 1'b0;
			end
		end
	end

	// bank swap and refill requests
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bank_o               <= 1'b0;
			kidx                 <= '0;
			update_weight_o      <= 1'b0;
			update_weight_addr_o <= '0;
		end else if (state == LOAD) begin
			bank_o <= 1'b0;
			kidx   <= '0;
		end else if (advance_o && kernel_end_i) begin
			bank_o <= ~bank_o;
			kidx   <= kidx + 4'd1;
			if (refill_need) begin
				update_weight_o      <= 1'b1;
				update_weight_addr_o <= bank_o ? BANK1_BASE : '0; // bank just freed
			end
		end else if (w_load_done_i) begin
			update_weight_o <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			end_d         <= '0;
			layer_ready_o <= 1'b0;
		end else begin
			end_d <= {end_d[0], layer_end_i};
			if (state != DONE) begin
				layer_ready_o <= 1'b0;
			end else if (end_d[1] && result_valid_i) begin
				layer_ready_o <= 1'b1; // final window has left the mac
			end
		end
	end

	a_fm_write_in_load: assert property (@(posedge clk) disable iff (!rst)
		fm_we_i |-> state == LOAD);

endmodule

`default_nettype wire

//--- conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv_mac #(
	parameter int ACC_W = cnn_pkg::ACC_W
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire cnn_pkg::data_t fm_i,
	input  wire cnn_pkg::data_t w_i,
	input  wire                 first_tap_i,
	input  wire                 last_tap_i,
	output cnn_pkg::acc_t       result_o,
	output logic                result_valid_o
);
	import cnn_pkg::*;

	logic                          first_d; // tap flags aligned to ram data
	logic                          last_d;
	logic signed [2*DATA_W-1:0]    prod;
	logic signed [ACC_W-1:0]       acc;
	logic signed [ACC_W-1:0]       sum;

	assign prod = fm_i * w_i;
	assign sum  = (first_d ? '0 : acc) + ACC_W'(prod); // restart on first tap

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			first_d <= 1'b0;
			last_d  <= 1'b0;
		end else begin
			first_d <= first_tap_i;
			last_d  <= last_tap_i;
		end
	end

	always_ff @(posedge clk) begin
		acc <= sum;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result_o       <= '0;
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= last_d;
			if (last_d) begin
				result_o <= sum; // window total incl. last product
			end
		end
	end

endmodule

`default_nettype wire

//--- conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_layer #(
	parameter int FM_SIZE_MAX = cnn_pkg::FM_SIZE_MAX,
	parameter int KS_MAX      = cnn_pkg::KS_MAX,
	parameter int DEPTH_MAX   = cnn_pkg::DEPTH_MAX,
	parameter int ACC_W       = cnn_pkg::ACC_W
) (
	input  wire                    clk,
	input  wire                    rst,
	input  wire [1:0]              layer_type_i,
	input  wire cnn_pkg::size_t    fm_size_i,
	input  wire cnn_pkg::size_t    kernel_size_i,
	input  wire cnn_pkg::size_t    fm_depth_i,
	input  wire cnn_pkg::size_t    kernel_num_i,
	input  wire                    fm_we_i,
	input  wire cnn_pkg::fm_addr_t fm_waddr_i,
	input  wire cnn_pkg::data_t    fm_wdata_i,
	input  wire                    fm_load_done_i,
	input  wire                    w_we_i,
	input  wire cnn_pkg::w_addr_t  w_waddr_i,
	input  wire cnn_pkg::data_t    w_wdata_i,
	input  wire                    w_load_done_i,
	output logic                   init_fm_ram_ready_o,
	output logic                   init_weight_ram_ready_o,
	output logic                   update_weight_o,
	output cnn_pkg::w_addr_t       update_weight_addr_o,
	output logic                   result_valid_o,
	output cnn_pkg::acc_t          result_o,
	output logic                   layer_ready_o
);
	import cnn_pkg::*;

	fm_addr_t fm_raddr;
	w_addr_t  w_raddr;
	data_t    fm_rdata;
	data_t    w_rdata;
	logic     advance;
	logic     clear;
	logic     bank;
	logic     first_tap;
	logic     last_tap;
	logic     kernel_end;
	logic     layer_end;

	fm_ram #(.FM_SIZE_MAX(FM_SIZE_MAX), .DEPTH_MAX(DEPTH_MAX)) i_fm_ram (
		.clk     (clk),
		.we_i    (fm_we_i),
		.waddr_i (fm_waddr_i),
		.wdata_i (fm_wdata_i),
		.raddr_i (fm_raddr),
		.rdata_o (fm_rdata)
	);

	// refill window given by the pending request
	weight_ram #(.KS_MAX(KS_MAX), .DEPTH_MAX(DEPTH_MAX)) i_weight_ram (
		.clk           (clk),
		.rst           (rst),
		.we_i          (w_we_i),
		.waddr_i       (w_waddr_i),
		.wdata_i       (w_wdata_i),
		.raddr_i       (w_raddr),
		.rdata_o       (w_rdata),
		.refill_i      (update_weight_o),
		.refill_base_i (update_weight_addr_o)
	);

	window_counter #(
		.FM_SIZE_MAX (FM_SIZE_MAX),
		.KS_MAX      (KS_MAX),
		.DEPTH_MAX   (DEPTH_MAX)
	) i_window_counter (
		.clk           (clk),
		.rst           (rst),
		.clear_i       (clear),
		.advance_i     (advance),
		.bank_i        (bank),
		.fm_size_i     (fm_size_i),
		.kernel_size_i (kernel_size_i),
		.fm_depth_i    (fm_depth_i),
		.kernel_num_i  (kernel_num_i),
		.fm_raddr_o    (fm_raddr),
		.w_raddr_o     (w_raddr),
		.first_tap_o   (first_tap),
		.last_tap_o    (last_tap),
		.kernel_end_o  (kernel_end),
		.layer_end_o   (layer_end)
	);

	conv_fsm #(.KS_MAX(KS_MAX), .DEPTH_MAX(DEPTH_MAX)) i_conv_fsm (
		.clk                     (clk),
		.rst                     (rst),
		.layer_type_i            (layer_type_i),
		.fm_load_done_i          (fm_load_done_i),
		.w_load_done_i           (w_load_done_i),
		.fm_we_i                 (fm_we_i),
		.w_we_i                  (w_we_i),
		.kernel_end_i            (kernel_end),
		.layer_end_i             (layer_end),
		.kernel_num_i            (kernel_num_i),
		.result_valid_i          (result_valid_o),
		.advance_o               (advance),
		.clear_o                 (clear),
		.bank_o                  (bank),
		.init_fm_ram_ready_o     (init_fm_ram_ready_o),
		.init_weight_ram_ready_o (init_weight_ram_ready_o),
		.update_weight_o         (update_weight_o),
		.update_weight_addr_o    (update_weight_addr_o),
		.layer_ready_o           (layer_ready_o)
	);

	conv_mac #(.ACC_W(ACC_W)) i_conv_mac (
		.clk            (clk),
		.rst            (rst),
		.fm_i           (fm_rdata),
		.w_i            (w_rdata),
		.first_tap_i    (first_tap),
		.last_tap_i     (last_tap),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

endmodule

`default_nettype wire

//--- tb_conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_layer;
	import cnn_pkg::*;

	// kernels x windows x depth x ks^2, summed over the four conv runs
	localparam int TAP_CYCLES  = 2*16*2*9 + 1*64*1*1 + 4*16*3*4 + 3*25*4*9;
	// fm words, weight words, refills with max delay, then pulses and drain
	localparam int LOAD_CYCLES = 10*64 + 4*72 + 3*(36 + 16 + 2) + 200;
	localparam int CYCLE_LIMIT = 2*TAP_CYCLES + LOAD_CYCLES;
	localparam int PLANE       = FM_SIZE_MAX * FM_SIZE_MAX;
	localparam int BANK        = DEPTH_MAX * KS_MAX * KS_MAX;

	logic       clk;
	logic       rst;
	logic [1:0] layer_type;
	size_t      fm_size;
	size_t      kernel_size;
	size_t      fm_depth;
	size_t      kernel_num;
	logic       fm_we;
	fm_addr_t   fm_waddr;
	data_t      fm_wdata;
	logic       fm_load_done;
	logic       w_we;
	w_addr_t    w_waddr;
	data_t      w_wdata;
	logic       w_load_done;
	logic       init_fm_ready;
	logic       init_w_ready;
	logic       update_weight;
	w_addr_t    update_weight_addr;
	logic       result_valid;
	acc_t       result;
	logic       layer_ready;

	int          fm_m [DEPTH_MAX][PLANE]; // model fm, slice then x*8+y
	int          w_m [KNUM_MAX][BANK];    // model weights per kernel
	int          exp_q [$];
	int          expk_q [$];              // kernel of each queued window
	int          n_results;
	int          refill_k = -1;           // kernel whose bank is being refilled
	string       test_name = "reset";
	int          test_errs = 0;
	int          err_total = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          cycle_cnt = 0;
	logic [31:0] lfsr;

	conv_layer i_conv_layer (
		.clk                     (clk),
		.rst                     (rst),
		.layer_type_i            (layer_type),
		.fm_size_i               (fm_size),
		.kernel_size_i           (kernel_size),
		.fm_depth_i              (fm_depth),
		.kernel_num_i            (kernel_num),
		.fm_we_i                 (fm_we),
		.fm_waddr_i              (fm_waddr),
		.fm_wdata_i              (fm_wdata),
		.fm_load_done_i          (fm_load_done),
		.w_we_i                  (w_we),
		.w_waddr_i               (w_waddr),
		.w_wdata_i               (w_wdata),
		.w_load_done_i           (w_load_done),
		.init_fm_ram_ready_o     (init_fm_ready),
		.init_weight_ram_ready_o (init_w_ready),
		.update_weight_o         (update_weight),
		.update_weight_addr_o    (update_weight_addr),
		.result_valid_o          (result_valid),
		.result_o                (result),
		.layer_ready_o           (layer_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout in test %s, run did not end within %0d cycles", test_name,
				CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// reference: sum over slice, ky, kx of fm x weight
	function automatic int window_sum(input int k, input int x, input int y, input int ks,
		input int depth);
		int sum;
		sum = 0;
		for (int s = 0; s < depth; s++) begin
			for (int ky = 0; ky < ks; ky++) begin
				for (int kx = 0; kx < ks; kx++) begin
					sum += fm_m[s][(x + kx) * FM_SIZE_MAX + (y + ky)]
						* w_m[k][s * KS_MAX * KS_MAX + ky * KS_MAX + kx];
				end
			end
		end
		return sum;
	endfunction

	task automatic count_error();
		test_errs++;
		err_total++;
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_bit(input string what, input logic exp, input logic got);
		if (got !== exp) begin
			$display("ERR %s: %s expected %0b, got %0b", test_name, what, exp, got);
			count_error();
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		if (test_errs == 0) begin
			tests_passed++;
			$display("test %s: passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, test_errs);
		end
	endtask

	always @(negedge clk) begin : result_check
		int e;
		int k;
		if (rst && result_valid) begin
			if (layer_ready) begin
				$display("test %s: result_valid_o seen after layer_ready_o", test_name);
				count_error();
			end
			if (exp_q.size() == 0) begin
				$display("test %s: result arrived with no window outstanding", test_name);
				count_error();
			end else begin
				e = exp_q.pop_front();
				k = expk_q.pop_front();
				// no kernel after the one that freed the bank may start before the refill
				if (refill_k >= 0 && k >= refill_k - 1) begin
					$display("test %s: result of kernel %0d came while a refill was pending",
						test_name, k);
					count_error();
				end
				if (int'(result) != e) begin
					$display("ERR %s: window %0d expected %0d, got %0d", test_name, n_results, e,
						int'(result));
					count_error();
				end
			end
			n_results++;
		end
	end

	// fm slices and both weight banks, then the two done pulses
	task automatic load_layer(input int depth);
		logic [31:0] v;
		layer_type = 2'd0;
		step();
		step(); // DONE back to LOAD
		for (int s = 0; s < depth; s++) begin
			for (int i = 0; i < PLANE; i++) begin
				rand_bits(DATA_W, v);
				fm_m[s][i] = $signed(v[DATA_W-1:0]);
				fm_we = 1'b1;
				fm_waddr = fm_addr_t'(s * PLANE + i);
				fm_wdata = v[DATA_W-1:0];
				step();
			end
		end
		fm_we = 1'b0;
		for (int k = 0; k < KNUM_MAX; k++) begin
			for (int i = 0; i < BANK; i++) begin
				rand_bits(DATA_W, v);
				w_m[k][i] = $signed(v[DATA_W-1:0]);
				if (k < 2) begin // kernels 0 and 1 go in now, the rest by refill
					w_we = 1'b1;
					w_waddr = w_addr_t'(k * BANK + i);
					w_wdata = v[DATA_W-1:0];
					step();
				end
			end
		end
		w_we = 1'b0;
		check_bit("init_fm_ram_ready_o", 1'b0, init_fm_ready);
		check_bit("init_weight_ram_ready_o", 1'b0, init_w_ready);
		fm_load_done = 1'b1;
		step();
		fm_load_done = 1'b0;
		check_bit("init_fm_ram_ready_o", 1'b1, init_fm_ready);
		check_bit("init_weight_ram_ready_o", 1'b0, init_w_ready);
		w_load_done = 1'b1;
		step();
		w_load_done = 1'b0;
		check_bit("init_fm_ram_ready_o", 1'b1, init_fm_ready);
		check_bit("init_weight_ram_ready_o", 1'b1, init_w_ready);
	endtask

	task automatic run_layer(input int fm, input int ks, input int depth, input int knum);
		int          win;
		int          rf_phase;
		int          rf_count;
		int          rf_idx;
		int          rf_base;
		logic [31:0] delay;
		win = fm - ks + 1;
		for (int k = 0; k < knum; k++) begin
			for (int x = 0; x < win; x++) begin
				for (int y = 0; y < win; y++) begin
					exp_q.push_back(window_sum(k, x, y, ks, depth));
					expk_q.push_back(k);
				end
			end
		end
		n_results = 0;
		rf_phase = 0;
		rf_count = 0;
		rf_idx = 0;
		rf_base = 0;
		fm_size = size_t'(fm);
		kernel_size = size_t'(ks);
		fm_depth = size_t'(depth);
		kernel_num = size_t'(knum);
		layer_type = 2'd1;
		while (!layer_ready) begin
			step();
			w_we = 1'b0;
			w_load_done = 1'b0;
			case (rf_phase)
				0: begin
					if (update_weight) begin
						// kernel k lives in bank k mod 2
						rf_base = ((rf_count + 2) % 2) * BANK;
						if (int'(update_weight_addr) != rf_base) begin
							$display("ERR %s: refill address expected %0d, got %0d", test_name,
								rf_base, int'(update_weight_addr));
							count_error();
						end
						refill_k = rf_count + 2;
						rf_count++;
						rand_bits(4, delay);
						rf_phase = 1;
					end
				end
				1: begin
					if (delay == 0) begin
						rf_idx = 0;
						rf_phase = 2;
					end else begin
						delay--;
					end
				end
				2: begin
					w_we = 1'b1;
					w_waddr = w_addr_t'(rf_base + rf_idx);
					w_wdata = data_t'(w_m[refill_k][rf_idx]);
					rf_idx++;
					if (rf_idx == BANK) begin
						rf_phase = 3;
					end
				end
				default: begin
					w_load_done = 1'b1; // ends the refill
					refill_k = -1;
					rf_phase = 0;
				end
			endcase
		end
		repeat (10) step(); // nothing may follow layer_ready_o
		if (exp_q.size() != 0) begin
			$display("test %s: %0d windows never produced a result", test_name, exp_q.size());
			count_error();
		end
		if (n_results != knum * win * win) begin
			$display("ERR %s: result count expected %0d, got %0d", test_name, knum * win * win,
				n_results);
			count_error();
		end
		if (rf_count != ((knum > 2) ? knum - 2 : 0)) begin
			$display("ERR %s: refill requests expected %0d, got %0d", test_name,
				(knum > 2) ? knum - 2 : 0, rf_count);
			count_error();
		end
		exp_q.delete();
		expk_q.delete();
	endtask

	initial begin
		lfsr = 32'h4d33;
		rst = 1'b0;
		layer_type = 2'd0;
		fm_size = '0;
		kernel_size = '0;
		fm_depth = '0;
		kernel_num = '0;
		fm_we = 1'b0;
		fm_waddr = '0;
		fm_wdata = '0;
		fm_load_done = 1'b0;
		w_we = 1'b0;
		w_waddr = '0;
		w_wdata = '0;
		w_load_done = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;

		start_test("load");
		load_layer(2);
		finish_test();

		start_test("conv_fm6_ks3_d2_k2");
		run_layer(6, 3, 2, 2);
		finish_test();

		start_test("conv_fm8_ks1_d1_k1");
		load_layer(1);
		run_layer(8, 1, 1, 1);
		finish_test();

		start_test("conv_fm5_ks2_d3_k4_refill");
		load_layer(3);
		run_layer(5, 2, 3, 4);
		finish_test();

		start_test("result_count_fm7_ks3_d4_k3");
		load_layer(4);
		run_layer(7, 3, 4, 3);
		finish_test();

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
			err_total);
		if (err_total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- conv_layer.f
cnn_pkg.sv
fm_ram.sv
weight_ram.sv
window_counter.sv
conv_fsm.sv
conv_mac.sv
conv_layer.sv
tb_conv_layer.sv
